//--- Bender.yml
package:
  name: mem_stage

sources:
  - src/mem_pkg.sv
  - src/mem_op_decoder.sv
  - src/data_memory.sv
  - src/mem_wb_latch.sv
  - src/debug_mem_reader.sv
  - src/mem_stage_top.sv
  - target: test
    files:
      - tests/mem_stage_checker.sv
      - tests/mem_stage_tb.sv

//--- src/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int WORD_LEN      = mem_pkg::WORD_LEN,
    parameter int MEM_CELL_SIZE = 8,
    parameter int DATA_MEM_SIZE = 16
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_step,
    input  mem_pkg::mem_req_t   i_req,
    input  logic [WORD_LEN-1:0] i_dbg_addr,
    output logic [WORD_LEN-1:0] o_data,
    output logic [WORD_LEN-1:0] o_dbg_data
);

    import mem_pkg::*;

    localparam int ADDR_W = $clog2(DATA_MEM_SIZE);

    logic [MEM_CELL_SIZE-1:0] mem [DATA_MEM_SIZE];

    logic [ADDR_W-1:0]        a0, a1, a2, a3;
    logic [ADDR_W-1:0]        d0, d1, d2, d3;
    logic [MEM_CELL_SIZE-1:0] b0, b1, b2, b3;
    logic                     sign_bit;
    logic                     store_en;
    logic [WORD_LEN-1:0]      load_ext;

    initial begin
        for (int i = 0; i < DATA_MEM_SIZE; i++) begin
            mem[i] = '0;
        end
    end

    // Cell addresses wrap inside the array.
    assign a0 = i_req.addr[ADDR_W-1:0];
    assign a1 = a0 + 1'b1;
    assign a2 = a0 + 2'd2;
    assign a3 = a0 + 2'd3;

    assign b0 = mem[a0];  // Most significant byte lives at the lowest address.
    assign b1 = mem[a1];
    assign b2 = mem[a2];
    assign b3 = mem[a3];

    assign store_en = i_step & i_req.write_en;
    assign sign_bit = b0[MEM_CELL_SIZE-1] & ~i_req.is_unsigned;

    always_comb begin
        case (i_req.size)
            SIZE_BYTE: load_ext = {{(WORD_LEN-MEM_CELL_SIZE){sign_bit}}, b0};
            SIZE_HALF: load_ext = {{(WORD_LEN-2*MEM_CELL_SIZE){sign_bit}}, b0, b1};
            default:   load_ext = {b0, b1, b2, b3};
        endcase
    end

    always @(negedge i_clk) begin
        if (!i_rst && store_en) begin
            case (i_req.size)
                SIZE_BYTE: mem[a0] <= i_req.wdata[MEM_CELL_SIZE-1:0];
                SIZE_HALF: {mem[a0], mem[a1]} <= i_req.wdata[2*MEM_CELL_SIZE-1:0];
                default:   {mem[a0], mem[a1], mem[a2], mem[a3]} <= i_req.wdata;
            endcase
        end
    end

    always_ff @(negedge i_clk) begin
        if (i_rst) begin
            o_data <= '0;
        end else if (!store_en) begin
            o_data <= load_ext;  // A store cycle keeps the last read.
        end
    end

    // The debug port sees the memory without waiting for a clock.
    assign d0 = i_dbg_addr[ADDR_W-1:0];
    assign d1 = d0 + 1'b1;
    assign d2 = d0 + 2'd2;
    assign d3 = d0 + 2'd3;

    assign o_dbg_data = {mem[d0], mem[d1], mem[d2], mem[d3]};

endmodule

//--- src/debug_mem_reader.sv
`timescale 1ns/1ps

module debug_mem_reader #(
    parameter int WORD_LEN      = 32,
    parameter int DATA_MEM_SIZE = 16
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_dump_start,
    input  logic [WORD_LEN-1:0] i_dbg_data,
    output logic [WORD_LEN-1:0] o_dbg_addr,
    output logic [WORD_LEN-1:0] o_dump_word,
    output logic                o_dump_valid,
    output logic                o_dump_done
);

    localparam int N_WORDS = DATA_MEM_SIZE / 4;
    localparam int CNT_W   = (N_WORDS > 1) ? $clog2(N_WORDS) : 1;

    typedef enum logic {
        ST_IDLE,
        ST_STREAM
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] word_idx;
    logic             last_word;

    assign last_word = (word_idx == CNT_W'(N_WORDS - 1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= ST_IDLE;
            word_idx    <= '0;
            o_dump_done <= 1'b0;
        end else begin
            o_dump_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_dump_start) begin
                        state    <= ST_STREAM;
                        word_idx <= '0;
                    end
                end
                ST_STREAM: begin
                    // Start pulses are ignored until the dump finishes.
                    if (last_word) begin
                        state       <= ST_IDLE;
                        o_dump_done <= 1'b1;
                    end else begin
                        word_idx <= word_idx + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Word index times four gives the byte address.
    assign o_dbg_addr   = {{(WORD_LEN-CNT_W-2){1'b0}}, word_idx, 2'b00};
    assign o_dump_word  = i_dbg_data;
    assign o_dump_valid = (state == ST_STREAM);

endmodule

//--- src/mem_op_decoder.sv
`timescale 1ns/1ps

module mem_op_decoder (
    input  logic [5:0]                   i_opcode,
    input  logic [mem_pkg::WORD_LEN-1:0] i_base,
    input  logic [15:0]                  i_imm,
    input  logic [4:0]                   i_rt,
    input  logic [mem_pkg::WORD_LEN-1:0] i_store_data,
    output mem_pkg::mem_req_t            o_req
);

    import mem_pkg::*;

    logic [WORD_LEN-1:0] offset;

    assign offset = {{(WORD_LEN-16){i_imm[15]}}, i_imm};  // Sign-extended displacement.

    always_comb begin
        o_req             = '0;
        o_req.rt          = i_rt;
        o_req.addr        = i_base + offset;
        o_req.wdata       = i_store_data;
        case (i_opcode)
            OP_LB: begin
                o_req.is_load = 1'b1;
                o_req.size    = SIZE_BYTE;
            end
            OP_LH: begin
                o_req.is_load = 1'b1;
                o_req.size    = SIZE_HALF;
            end
            OP_LW: begin
                o_req.is_load = 1'b1;
                o_req.size    = SIZE_WORD;
            end
            OP_LBU: begin
                o_req.is_load     = 1'b1;
                o_req.size        = SIZE_BYTE;
                o_req.is_unsigned = 1'b1;
            end
            OP_LHU: begin
                o_req.is_load     = 1'b1;
                o_req.size        = SIZE_HALF;
                o_req.is_unsigned = 1'b1;
            end
            OP_SB: begin
                o_req.write_en = 1'b1;
                o_req.size     = SIZE_BYTE;
            end
            OP_SH: begin
                o_req.write_en = 1'b1;
                o_req.size     = SIZE_HALF;
            end
            OP_SW: begin
                o_req.write_en = 1'b1;
                o_req.size     = SIZE_WORD;
            end
            default: begin
                // Not a memory operation, so the result comes from the ALU.
                o_req.size = SIZE_WORD;
            end
        endcase
    end

endmodule

//--- src/mem_pkg.sv
package mem_pkg;

    // Data and address width of the stage.
    localparam int WORD_LEN = 32;

    // Load opcodes.
    localparam logic [5:0] OP_LB  = 6'b100000;
    localparam logic [5:0] OP_LH  = 6'b100001;
    localparam logic [5:0] OP_LW  = 6'b100011;
    localparam logic [5:0] OP_LBU = 6'b100100;
    localparam logic [5:0] OP_LHU = 6'b100101;

    // Store opcodes.
    localparam logic [5:0] OP_SB  = 6'b101000;
    localparam logic [5:0] OP_SH  = 6'b101001;
    localparam logic [5:0] OP_SW  = 6'b101011;

    // Access size codes as the data memory decodes them.
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b11;

    // One memory request, built by the decoder each cycle.
    typedef struct packed {
        logic                is_load;
        logic                write_en;
        logic [1:0]          size;
        logic                is_unsigned;   // Zero-extend the load.
        logic [4:0]          rt;
        logic [WORD_LEN-1:0] addr;
        logic [WORD_LEN-1:0] wdata;
    } mem_req_t;

    // Record handed to the register file write port.
    typedef struct packed {
        logic                reg_write;
        logic [4:0]          rd;
        logic [WORD_LEN-1:0] value;
    } wb_t;

endpackage

//--- src/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top #(
    parameter int MEM_CELL_SIZE = 8,
    parameter int DATA_MEM_SIZE = 16
) (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_step,
    input  logic [5:0]                   i_opcode,
    input  logic [mem_pkg::WORD_LEN-1:0] i_base,
    input  logic [15:0]                  i_imm,
    input  logic [4:0]                   i_rt,
    input  logic [mem_pkg::WORD_LEN-1:0] i_store_data,
    input  logic [mem_pkg::WORD_LEN-1:0] i_alu_result,
    input  logic                         i_dump_start,
    output mem_pkg::wb_t                 o_wb,
    output logic [mem_pkg::WORD_LEN-1:0] o_dump_word,
    output logic                         o_dump_valid,
    output logic                         o_dump_done
);

    import mem_pkg::*;

    mem_req_t            req;
    logic [WORD_LEN-1:0] load_data;
    logic [WORD_LEN-1:0] dbg_addr;
    logic [WORD_LEN-1:0] dbg_data;

    mem_op_decoder u_decoder (
        .i_opcode     (i_opcode),
        .i_base       (i_base),
        .i_imm        (i_imm),
        .i_rt         (i_rt),
        .i_store_data (i_store_data),
        .o_req        (req)
    );

    data_memory #(
        .WORD_LEN      (WORD_LEN),
        .MEM_CELL_SIZE (MEM_CELL_SIZE),
        .DATA_MEM_SIZE (DATA_MEM_SIZE)
    ) u_data_memory (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_step     (i_step),
        .i_req      (req),
        .i_dbg_addr (dbg_addr),
        .o_data     (load_data),
        .o_dbg_data (dbg_data)
    );

    mem_wb_latch u_wb_latch (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_step       (i_step),
        .i_req        (req),
        .i_load_data  (load_data),
        .i_alu_result (i_alu_result),
        .o_wb         (o_wb)
    );

    // Shares the memory with the stage through the combinational debug port.
    debug_mem_reader #(
        .WORD_LEN      (WORD_LEN),
        .DATA_MEM_SIZE (DATA_MEM_SIZE)
    ) u_dump (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_dump_start (i_dump_start),
        .i_dbg_data   (dbg_data),
        .o_dbg_addr   (dbg_addr),
        .o_dump_word  (o_dump_word),
        .o_dump_valid (o_dump_valid),
        .o_dump_done  (o_dump_done)
    );

endmodule

//--- src/mem_wb_latch.sv
`timescale 1ns/1ps

module mem_wb_latch (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_step,
    input  mem_pkg::mem_req_t            i_req,
    input  logic [mem_pkg::WORD_LEN-1:0] i_load_data,
    input  logic [mem_pkg::WORD_LEN-1:0] i_alu_result,
    output mem_pkg::wb_t                 o_wb
);

    import mem_pkg::*;

    wb_t wb_next;

    always_comb begin
        wb_next.reg_write = ~i_req.write_en;  // Only stores leave the register file alone.
        wb_next.rd        = i_req.rt;
        if (i_req.is_load) begin
            wb_next.value = i_load_data;
        end else begin
            wb_next.value = i_alu_result;
        end
    end

    // The record advances only when the debug unit steps the pipeline.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb <= '0;
        end else if (i_step) begin
            o_wb <= wb_next;
        end
    end

endmodule

//--- tb.f
src/mem_pkg.sv
src/mem_op_decoder.sv
src/data_memory.sv
src/mem_wb_latch.sv
src/debug_mem_reader.sv
src/mem_stage_top.sv
tests/mem_stage_checker.sv
tests/mem_stage_tb.sv

//--- tests/mem_stage_checker.sv
`timescale 1ns/1ps

module mem_stage_checker #(
    parameter int DATA_MEM_SIZE = 16
) (
    input logic                         i_clk,
    input mem_pkg::wb_t                 i_wb,
    input logic [mem_pkg::WORD_LEN-1:0] i_dump_word,
    input logic                         i_dump_valid,
    input logic                         i_dump_done
);

    import mem_pkg::*;

    localparam int N_WORDS      = DATA_MEM_SIZE / 4;
    localparam int DUMP_TIMEOUT = 4 * N_WORDS + 20;  // In clock cycles.

    int test_count;
    int fail_count;
    int err_count;

    initial begin
        test_count = 0;
        fail_count = 0;
        err_count  = 0;
    end

    task automatic compare_value(input string test, input string field,
                                 input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: %s got 0x%0h, expected 0x%0h", test, field, got, exp);
            err_count++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (err_count > errs_before) begin
            fail_count++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic check_idle(input string name);
        int errs_before;
        errs_before = err_count;
        compare_value(name, "o_wb.value", i_wb.value, '0);
        compare_value(name, "o_wb.reg_write", i_wb.reg_write, 1'b0);
        compare_value(name, "o_wb.rd", i_wb.rd, 5'd0);
        compare_value(name, "o_dump_valid", i_dump_valid, 1'b0);
        compare_value(name, "o_dump_done", i_dump_done, 1'b0);
        finish_test(name, errs_before);
    endtask

    // Called one falling edge after the stepping rising edge, so o_wb is settled.
    task automatic check_wb(input string name, input wb_t exp);
        int errs_before;
        errs_before = err_count;
        compare_value(name, "o_wb.value", i_wb.value, exp.value);
        compare_value(name, "o_wb.reg_write", i_wb.reg_write, exp.reg_write);
        compare_value(name, "o_wb.rd", i_wb.rd, exp.rd);
        finish_test(name, errs_before);
    endtask

    task automatic collect_dump(input string name, input logic [N_WORDS*32-1:0] exp_words);
        int errs_before;
        int cycles;
        int n_valid;
        bit done_seen;
        errs_before = err_count;
        cycles      = 0;
        n_valid     = 0;
        done_seen   = 1'b0;
        while (!i_dump_valid && cycles < DUMP_TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!i_dump_valid) begin
            note_failure({name, ": the dump never raised o_dump_valid"});
        end else begin
            cycles = 0;
            while (!done_seen && cycles < DUMP_TIMEOUT) begin
                if (i_dump_valid) begin
                    if (n_valid < N_WORDS) begin
                        compare_value(name, $sformatf("o_dump_word[%0d]", n_valid),
                                      i_dump_word, exp_words[n_valid*32 +: 32]);
                    end
                    n_valid++;
                end
                done_seen = i_dump_done;
                @(negedge i_clk);
                cycles++;
            end
            if (!done_seen) begin
                note_failure({name, ": timed out waiting for o_dump_done"});
            end else begin
                compare_value(name, "o_dump_valid cycle count", n_valid, N_WORDS);
                compare_value(name, "o_dump_done after pulse", i_dump_done, 1'b0);
            end
        end
        finish_test(name, errs_before);
    endtask

    task automatic report();
        $display("summary: %0d tests, %0d failed, %0d errors", test_count, fail_count, err_count);
    endtask

endmodule

//--- tests/mem_stage_stimulus.txt
# op   name kind opcode base imm rt store_data step exp_value exp_reg_write (hex)
# dump name word0 word1 word2 word3 ; kind L load, S store, A ALU (random value)
op sw_neg_imm    S 2b 00000010 fff0 08 12345678 1 5a5a0001 0
op lw_neg_imm    L 23 00000008 fff8 09 00000000 1 12345678 1
op sw_word4      S 2b 00000000 0004 0a 11223344 1 5a5a0002 0
op sb_byte5      S 28 00000004 0001 0b 000000aa 1 5a5a0003 0
op sh_half6      S 29 00000004 0002 0c 0000beef 1 5a5a0004 0
op lw_merged     L 23 00000000 0004 0d 00000000 1 11aabeef 1
op sw_word8      S 2b 00000008 0000 0e 9c8e7f01 1 5a5a0005 0
op lb_neg        L 20 00000008 0000 0f 00000000 1 ffffff9c 1
op lbu_neg       L 24 00000008 0000 10 00000000 1 0000009c 1
op lh_neg        L 21 00000008 0000 11 00000000 1 ffff9c8e 1
op lhu_neg       L 25 00000008 0000 12 00000000 1 00009c8e 1
op lb_pos        L 20 0000000c fffe 13 00000000 1 0000007f 1
# Store with step low: memory and o_wb must keep their values.
op sw_no_step    S 2b 0000000c 0000 14 deadbeef 0 0000007f 1
op lw_unchanged  L 23 0000000c 0000 15 00000000 1 00000000 1
op alu_pass      A 00 00000000 0000 16 00000000 1 00000000 1
op alu_pass2     A 3f 00000004 0000 19 00000000 1 00000000 1
op sw_word12     S 2b 0000000c 0000 17 cafef00d 1 5a5a0006 0
op lw_word12     L 23 00000010 fffc 18 00000000 1 cafef00d 1
op lhu_pos       L 25 00000004 0002 1a 00000000 1 0000beef 1
op lh_neg2       L 21 00000004 0002 1b 00000000 1 ffffbeef 1
dump dump_all    12345678 11aabeef 9c8e7f01 cafef00d

//--- tests/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;

    import mem_pkg::*;

    localparam int MEM_CELL_SIZE = 8;
    localparam int DATA_MEM_SIZE = 16;
    localparam int N_WORDS       = DATA_MEM_SIZE / 4;
    localparam int CLK_PERIOD    = 40;

    logic                clk;
    logic                rst;
    logic                step;
    logic [5:0]          opcode;
    logic [WORD_LEN-1:0] base;
    logic [15:0]         imm;
    logic [4:0]          rt;
    logic [WORD_LEN-1:0] store_data;
    logic [WORD_LEN-1:0] alu_result;
    logic                dump_start;
    wb_t                 wb;
    logic [WORD_LEN-1:0] dump_word;
    logic                dump_valid;
    logic                dump_done;

    wb_t exp_wb;  // What o_wb should hold after the latest operation.

    mem_stage_top #(
        .MEM_CELL_SIZE (MEM_CELL_SIZE),
        .DATA_MEM_SIZE (DATA_MEM_SIZE)
    ) UUT (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_step       (step),
        .i_opcode     (opcode),
        .i_base       (base),
        .i_imm        (imm),
        .i_rt         (rt),
        .i_store_data (store_data),
        .i_alu_result (alu_result),
        .i_dump_start (dump_start),
        .o_wb         (wb),
        .o_dump_word  (dump_word),
        .o_dump_valid (dump_valid),
        .o_dump_done  (dump_done)
    );

    mem_stage_checker #(
        .DATA_MEM_SIZE (DATA_MEM_SIZE)
    ) chk (
        .i_clk        (clk),
        .i_wb         (wb),
        .i_dump_word  (dump_word),
        .i_dump_valid (dump_valid),
        .i_dump_done  (dump_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Setup edge with i_step low, then the step edge, then a release edge where the
    // memory commits the store and o_wb has settled.
    task automatic run_op(input string name, input string kind, input logic [5:0] op,
                          input logic [31:0] b, input logic [15:0] im, input logic [4:0] r,
                          input logic [31:0] sd, input logic st, input logic [31:0] ev,
                          input logic erw);
        logic [31:0] alu;
        logic [31:0] exp_value;
        exp_value = ev;
        if (kind == "A" && st) begin
            alu       = $urandom;
            exp_value = alu;
        end else if (kind == "S" && st) begin
            alu = ev;
        end else begin
            alu = ~ev;  // Loads and unstepped lines must not show this value.
        end
        @(negedge clk);
        opcode     <= op;
        base       <= b;
        imm        <= im;
        rt         <= r;
        store_data <= sd;
        alu_result <= alu;
        step       <= 1'b0;
        @(negedge clk);
        step <= st;
        @(negedge clk);
        step <= 1'b0;
        exp_wb.value     = exp_value;
        exp_wb.reg_write = erw;
        if (st) begin
            exp_wb.rd = r;
        end
        chk.check_wb(name, exp_wb);
    endtask

    task automatic run_dump(input string name, input logic [N_WORDS*32-1:0] words);
        @(negedge clk);
        dump_start <= 1'b1;
        @(negedge clk);
        dump_start <= 1'b0;
        chk.collect_dump(name, words);
    endtask

    task automatic parse_line(input logic [8*160-1:0] line_buf);
        string       tag;
        string       name;
        string       kind;
        int          code;
        logic [31:0] op_f, base_f, imm_f, rt_f, sdata_f, step_f, exp_f, rw_f;
        logic [31:0] w0, w1, w2, w3;
        tag  = "";
        code = $sscanf(line_buf, "%s", tag);
        if (code >= 1 && tag != "#") begin
            if (tag == "op") begin
                code = $sscanf(line_buf, "%s %s %s %h %h %h %h %h %h %h %h", tag, name, kind,
                               op_f, base_f, imm_f, rt_f, sdata_f, step_f, exp_f, rw_f);
                if (code != 11) begin
                    chk.note_failure("an op line in the stimulus file has missing fields");
                end else begin
                    run_op(name, kind, op_f[5:0], base_f, imm_f[15:0], rt_f[4:0], sdata_f,
                           step_f[0], exp_f, rw_f[0]);
                end
            end else if (tag == "dump") begin
                code = $sscanf(line_buf, "%s %s %h %h %h %h", tag, name, w0, w1, w2, w3);
                if (code != 6) begin
                    chk.note_failure("a dump line in the stimulus file has missing fields");
                end else begin
                    run_dump(name, {w3, w2, w1, w0});
                end
            end else begin
                chk.note_failure({"unknown line kind in the stimulus file: ", tag});
            end
        end
    endtask

    initial begin
        int               fd;
        int               rng_seed;
        int unsigned      seed_val;
        logic [8*160-1:0] line_buf;
        rst        = 1'b1;
        step       = 1'b0;
        opcode     = '0;
        base       = '0;
        imm        = '0;
        rt         = '0;
        store_data = '0;
        alu_result = '0;
        dump_start = 1'b0;
        exp_wb     = '0;
        rng_seed   = 60;
        seed_val   = $urandom(rng_seed);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        chk.check_idle("after_reset");
        fd = $fopen("tests/mem_stage_stimulus.txt", "r");
        if (fd == 0) begin
            chk.note_failure("could not open tests/mem_stage_stimulus.txt");
        end else begin
            while ($fgets(line_buf, fd) != 0) begin
                parse_line(line_buf);
                line_buf = '0;
            end
            $fclose(fd);
        end
        if (chk.test_count < 2) begin
            chk.note_failure("no test lines were run from the stimulus file");
        end
        chk.report();
        if (chk.err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
